// ==== design/snake_geom_pkg.sv ====
`default_nettype none

// grid geometry, colours and segment types used across the datapath
package snake_geom_pkg;

	// x spans 0..159, y spans 0..119
	typedef logic [7:0] coord_x_t;
	typedef logic [6:0] coord_y_t;
	// one bit per channel, red in the msb
	typedef logic [2:0] colour_t;
	// segment count, also used as a segment index
	typedef logic [7:0] seg_count_t;
	// random word, split into two 7-bit apple fields
	typedef logic [13:0] rand_t;

	localparam int GRID_W = 160;
	localparam int GRID_H = 120;
	// border wall thickness in cells
	localparam int WALL_T = 2;
	// range of one apple field after folding, before the wall offset
	localparam int APPLE_SPAN = 100;

	// start snake: head at (30,20), body trailing to the right
	localparam coord_x_t START_X = 8'd30;
	localparam coord_y_t START_Y = 7'd20;
	localparam seg_count_t START_LEN = 8'd5;

	localparam colour_t COLOUR_BLACK = 3'b000;
	localparam colour_t COLOUR_BLUE = 3'b001;
	localparam colour_t COLOUR_RED = 3'b100;

	// rainbow palette, entry 0 on the left
	localparam int RAINBOW_N = 6;
	localparam colour_t [0:RAINBOW_N-1] RAINBOW = {
		3'b100,
		3'b110,
		3'b010,
		3'b011,
		3'b001,
		3'b101
	};

endpackage

`default_nettype wire

// ==== design/snake_game_pkg.sv ====
`default_nettype none

// sequencer states and steering directions
package snake_game_pkg;

	typedef enum logic [4:0] {
		ST_IDLE,
		ST_ARM,
		ST_LOAD,
		ST_PLACE_APPLE,
		ST_CLEAR,
		ST_WALLS,
		ST_APPLE,
		ST_SNAKE,
		ST_DELAY,
		ST_MOVE,
		ST_CHECK,
		ST_EAT,
		ST_DEAD,
		ST_OVER
	} game_state_t;

	// left and right step x, down and up step y
	typedef enum logic [1:0] {
		DIR_LEFT = 2'd0,
		DIR_RIGHT = 2'd1,
		DIR_DOWN = 2'd2,
		DIR_UP = 2'd3
	} dir_t;

endpackage

`default_nettype wire

// ==== design/snake_control.sv ====
`timescale 1ns/1ns
`default_nettype none

module snake_control import snake_game_pkg::*; #(
	parameter int DELAY_TICKS = 10_000_000
) (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        mv_left,
	input  logic        mv_right,
	input  logic        mv_down,
	input  logic        mv_up,
	input  logic        paint_done,
	input  logic        scan_last,
	input  logic        collision,
	input  logic        apple_hit,
	output game_state_t game_state,
	output dir_t        direction,
	output logic        scan_load,
	output logic        dead
);

	// delay counter runs 0 .. DELAY_TICKS-1
	localparam int DCW = (DELAY_TICKS > 1) ? $clog2(DELAY_TICKS) : 1;

	game_state_t state_nxt;
	dir_t dir_q;
	dir_t dir_steer;
	logic press;
	logic delay_done;
	logic [DCW-1:0] delay_cnt;

	// any direction key doubles as the start button
	assign press = mv_left | mv_right | mv_down | mv_up;
	assign delay_done = (delay_cnt == DCW'(DELAY_TICKS - 1));

	// steering request, first match wins, reversals dropped
	always_comb begin
		dir_steer = dir_q;
		if (mv_left && dir_q != DIR_RIGHT)
			dir_steer = DIR_LEFT;
		else if (mv_right && dir_q != DIR_LEFT)
			dir_steer = DIR_RIGHT;
		else if (mv_down && dir_q != DIR_UP)
			dir_steer = DIR_DOWN;
		else if (mv_up && dir_q != DIR_DOWN)
			dir_steer = DIR_UP;
	end

	// the move cycle already steps along the new request
	assign direction = (game_state == ST_MOVE) ? dir_steer : dir_q;

	always_comb begin
		state_nxt = game_state;
		case (game_state)
			ST_IDLE, ST_OVER:
				if (press)
					state_nxt = ST_ARM;
			// wait for the key to come back up
			ST_ARM:
				if (!press)
					state_nxt = ST_LOAD;
			ST_LOAD: state_nxt = ST_PLACE_APPLE;
			ST_PLACE_APPLE: state_nxt = ST_CLEAR;
			ST_CLEAR:
				if (paint_done)
					state_nxt = ST_WALLS;
			ST_WALLS:
				if (paint_done)
					state_nxt = ST_APPLE;
			ST_APPLE: state_nxt = ST_SNAKE;
			ST_SNAKE:
				if (scan_last)
					state_nxt = ST_DELAY;
			ST_DELAY:
				if (delay_done)
					state_nxt = ST_MOVE;
			ST_MOVE: state_nxt = ST_CHECK;
			// collision wins over eating
			ST_CHECK:
				if (scan_last) begin
					if (collision)
						state_nxt = ST_DEAD;
					else if (apple_hit)
						state_nxt = ST_EAT;
					else
						state_nxt = ST_CLEAR;
				end
			ST_EAT: state_nxt = ST_PLACE_APPLE;
			ST_DEAD: state_nxt = ST_OVER;
			default: state_nxt = ST_IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			game_state <= ST_IDLE;
			dir_q <= DIR_LEFT;
			delay_cnt <= '0;
			scan_load <= 1'b0;
		end else begin
			game_state <= state_nxt;
			// a new game always heads left
			if (game_state == ST_LOAD)
				dir_q <= DIR_LEFT;
			else if (game_state == ST_MOVE)
				dir_q <= dir_steer;
			if (game_state == ST_DELAY && !delay_done)
				delay_cnt <= delay_cnt + 1'b1;
			else
				delay_cnt <= '0;
			// high on the first cycle of each body scan
			scan_load <= (state_nxt == ST_SNAKE && game_state != ST_SNAKE) ||
				(state_nxt == ST_CHECK && game_state != ST_CHECK);
		end
	end

	assign dead = (game_state == ST_DEAD);

endmodule

`default_nettype wire

// ==== design/snake_body.sv ====
`timescale 1ns/1ns
`default_nettype none

module snake_body import snake_geom_pkg::*, snake_game_pkg::*; #(
	parameter int MAX_LEN = 128
) (
	input  logic        clk,
	input  logic        rst_n,
	input  game_state_t game_state,
	input  dir_t        direction,
	input  logic        scan_load,
	output coord_x_t    head_x,
	output coord_y_t    head_y,
	output coord_x_t    scan_x,
	output coord_y_t    scan_y,
	output colour_t     scan_colour,
	output logic        scan_first,
	output logic        scan_last,
	output seg_count_t  snake_size
);

	// segment 0 is the head
	coord_x_t seg_x [MAX_LEN];
	coord_y_t seg_y [MAX_LEN];
	colour_t seg_c [MAX_LEN];
	// scan walker copy, shifts toward index 0
	coord_x_t walk_x [MAX_LEN];
	coord_y_t walk_y [MAX_LEN];
	colour_t walk_c [MAX_LEN];
	coord_x_t src_x [MAX_LEN];
	coord_y_t src_y [MAX_LEN];
	colour_t src_c [MAX_LEN];
	seg_count_t scan_idx;
	seg_count_t cur_idx;
	logic walking;

	// palette entry before c, p0 wraps to p5
	function automatic colour_t palette_prev(colour_t c);
		colour_t p;
		p = RAINBOW[RAINBOW_N-1];
		for (int i = 1; i < RAINBOW_N; i++)
			if (c == RAINBOW[i])
				p = RAINBOW[i-1];
		return p;
	endfunction

	assign head_x = seg_x[0];
	assign head_y = seg_y[0];
	assign walking = (game_state == ST_SNAKE) || (game_state == ST_CHECK);

	// on the load cycle the live segments feed the walker directly
	always_comb begin
		for (int i = 0; i < MAX_LEN; i++) begin
			src_x[i] = scan_load ? seg_x[i] : walk_x[i];
			src_y[i] = scan_load ? seg_y[i] : walk_y[i];
			src_c[i] = scan_load ? seg_c[i] : walk_c[i];
		end
	end

	assign cur_idx = scan_load ? '0 : scan_idx;
	assign scan_x = src_x[0];
	assign scan_y = src_y[0];
	assign scan_colour = src_c[0];
	assign scan_first = scan_load;
	assign scan_last = walking && (cur_idx == snake_size - 1'b1);

	always_ff @(posedge clk) begin
		case (game_state)
			ST_LOAD:
				for (int i = 0; i < START_LEN; i++) begin
					seg_x[i] <= START_X + coord_x_t'(i);
					seg_y[i] <= START_Y;
					seg_c[i] <= RAINBOW[i];
				end
			ST_MOVE: begin
				// every segment takes the place of the one ahead
				for (int i = 1; i < MAX_LEN; i++) begin
					seg_x[i] <= seg_x[i-1];
					seg_y[i] <= seg_y[i-1];
				end
				case (direction)
					DIR_LEFT: seg_x[0] <= seg_x[0] - 1'b1;
					DIR_RIGHT: seg_x[0] <= seg_x[0] + 1'b1;
					DIR_DOWN: seg_y[0] <= seg_y[0] + 1'b1;
					default: seg_y[0] <= seg_y[0] - 1'b1;
				endcase
			end
			// colours move tailward, new head takes the next rainbow colour
			ST_EAT: begin
				for (int i = 1; i < MAX_LEN; i++)
					seg_c[i] <= seg_c[i-1];
				seg_c[0] <= palette_prev(seg_c[0]);
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk) begin
		if (walking) begin
			for (int i = 0; i < MAX_LEN - 1; i++) begin
				walk_x[i] <= src_x[i+1];
				walk_y[i] <= src_y[i+1];
				walk_c[i] <= src_c[i+1];
			end
			walk_x[MAX_LEN-1] <= src_x[MAX_LEN-1];
			walk_y[MAX_LEN-1] <= src_y[MAX_LEN-1];
			walk_c[MAX_LEN-1] <= src_c[MAX_LEN-1];
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			snake_size <= '0;
			scan_idx <= '0;
		end else begin
			// growth saturates at capacity
			if (game_state == ST_LOAD)
				snake_size <= START_LEN;
			else if (game_state == ST_EAT && snake_size < MAX_LEN)
				snake_size <= snake_size + 1'b1;
			if (walking)
				scan_idx <= cur_idx + 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== design/apple_placer.sv ====
`timescale 1ns/1ns
`default_nettype none

module apple_placer import snake_geom_pkg::*, snake_game_pkg::*; (
	input  logic        clk,
	input  logic        rst_n,
	input  game_state_t game_state,
	input  rand_t       random_in,
	output coord_x_t    apple_x,
	output coord_y_t    apple_y
);

	// fold 0..127 into 0..99, then step past the wall
	function automatic logic [6:0] fold(logic [6:0] v);
		logic [6:0] f;
		f = (v >= APPLE_SPAN) ? v - 7'(APPLE_SPAN) : v;
		return f + 7'(WALL_T);
	endfunction

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			apple_x <= '0;
			apple_y <= '0;
		end else if (game_state == ST_PLACE_APPLE) begin
			// low field for x, high field for y
			apple_x <= coord_x_t'(fold(random_in[6:0]));
			apple_y <= fold(random_in[13:7]);
		end
	end

endmodule

`default_nettype wire

// ==== design/frame_painter.sv ====
`timescale 1ns/1ns
`default_nettype none

module frame_painter import snake_geom_pkg::*, snake_game_pkg::*; (
	input  logic        clk,
	input  logic        rst_n,
	input  game_state_t game_state,
	input  coord_x_t    apple_x,
	input  coord_y_t    apple_y,
	input  coord_x_t    scan_x,
	input  coord_y_t    scan_y,
	input  colour_t     scan_colour,
	output logic        plot,
	output coord_x_t    draw_x,
	output coord_y_t    draw_y,
	output colour_t     colour,
	output logic        paint_done
);

	// raster position, x inner
	coord_x_t rx;
	coord_y_t ry;
	logic sweeping;
	logic row_end;
	logic in_wall;

	assign sweeping = (game_state == ST_CLEAR) || (game_state == ST_WALLS);
	assign row_end = (rx == coord_x_t'(GRID_W - 1));
	assign paint_done = sweeping && row_end && (ry == coord_y_t'(GRID_H - 1));

	// wall band on all four sides
	assign in_wall = (rx < WALL_T) || (rx >= GRID_W - WALL_T) ||
		(ry < WALL_T) || (ry >= GRID_H - WALL_T);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rx <= '0;
			ry <= '0;
		end else if (sweeping) begin
			// wraps to (0,0) after the last pixel, ready for the next sweep
			if (row_end) begin
				rx <= '0;
				ry <= paint_done ? '0 : ry + 1'b1;
			end else begin
				rx <= rx + 1'b1;
			end
		end
	end

	// strobe, one cycle behind the producing state cycle
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			plot <= 1'b0;
		else begin
			case (game_state)
				ST_CLEAR, ST_APPLE, ST_SNAKE: plot <= 1'b1;
				// wall sweep plots only band pixels
				ST_WALLS: plot <= in_wall;
				default: plot <= 1'b0;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		case (game_state)
			ST_CLEAR, ST_WALLS: begin
				draw_x <= rx;
				draw_y <= ry;
				colour <= (game_state == ST_CLEAR) ? COLOUR_BLACK : COLOUR_BLUE;
			end
			ST_APPLE: begin
				draw_x <= apple_x;
				draw_y <= apple_y;
				colour <= COLOUR_RED;
			end
			// one segment per cycle from the body walker
			ST_SNAKE: begin
				draw_x <= scan_x;
				draw_y <= scan_y;
				colour <= scan_colour;
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

// ==== design/collision_checker.sv ====
`timescale 1ns/1ns
`default_nettype none

module collision_checker import snake_geom_pkg::*, snake_game_pkg::*; (
	input  logic        clk,
	input  logic        rst_n,
	input  game_state_t game_state,
	input  coord_x_t    head_x,
	input  coord_y_t    head_y,
	input  coord_x_t    scan_x,
	input  coord_y_t    scan_y,
	input  logic        scan_first,
	input  coord_x_t    apple_x,
	input  coord_y_t    apple_y,
	output logic        collision,
	output logic        apple_hit
);

	logic hit_flag;
	logic hit_now;
	logic scan_in_wall;

	// a step below 0 wraps high and still lands in the band
	assign scan_in_wall = (scan_x < WALL_T) || (scan_x >= GRID_W - WALL_T) ||
		(scan_y < WALL_T) || (scan_y >= GRID_H - WALL_T);

	// head segment is tested against the walls, the rest against the head
	always_comb begin
		hit_now = 1'b0;
		if (game_state == ST_CHECK) begin
			if (scan_first)
				hit_now = scan_in_wall;
			else
				hit_now = (scan_x == head_x) && (scan_y == head_y);
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			hit_flag <= 1'b0;
		else if (game_state == ST_LOAD)
			hit_flag <= 1'b0;
		else if (hit_now)
			hit_flag <= 1'b1;
	end

	// include this cycle's compare so the last segment counts at scan end
	assign collision = hit_flag | hit_now;
	assign apple_hit = (head_x == apple_x) && (head_y == apple_y);

endmodule

`default_nettype wire

// ==== design/snake_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module snake_top import snake_geom_pkg::*, snake_game_pkg::*; #(
	parameter int MAX_LEN = 128,
	parameter int DELAY_TICKS = 10_000_000
) (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       mv_left,
	input  logic       mv_right,
	input  logic       mv_down,
	input  logic       mv_up,
	input  rand_t      random_in,
	output logic       plot,
	output coord_x_t   draw_x,
	output coord_y_t   draw_y,
	output colour_t    colour,
	output seg_count_t snake_size,
	output logic       dead
);

	// sequencer to datapath
	game_state_t game_state;
	dir_t direction;
	logic scan_load;

	// datapath back to sequencer
	logic paint_done;
	logic scan_last;
	logic collision;
	logic apple_hit;

	// body and apple positions
	coord_x_t head_x;
	coord_y_t head_y;
	coord_x_t scan_x;
	coord_y_t scan_y;
	colour_t scan_colour;
	logic scan_first;
	coord_x_t apple_x;
	coord_y_t apple_y;

	snake_control #(
		.DELAY_TICKS(DELAY_TICKS)
	) snake_control_inst (
		.clk        (clk),
		.rst_n      (rst_n),
		.mv_left    (mv_left),
		.mv_right   (mv_right),
		.mv_down    (mv_down),
		.mv_up      (mv_up),
		.paint_done (paint_done),
		.scan_last  (scan_last),
		.collision  (collision),
		.apple_hit  (apple_hit),
		.game_state (game_state),
		.direction  (direction),
		.scan_load  (scan_load),
		.dead       (dead)
	);

	snake_body #(
		.MAX_LEN(MAX_LEN)
	) snake_body_inst (
		.clk         (clk),
		.rst_n       (rst_n),
		.game_state  (game_state),
		.direction   (direction),
		.scan_load   (scan_load),
		.head_x      (head_x),
		.head_y      (head_y),
		.scan_x      (scan_x),
		.scan_y      (scan_y),
		.scan_colour (scan_colour),
		.scan_first  (scan_first),
		.scan_last   (scan_last),
		.snake_size  (snake_size)
	);

	apple_placer apple_placer_inst (
		.clk        (clk),
		.rst_n      (rst_n),
		.game_state (game_state),
		.random_in  (random_in),
		.apple_x    (apple_x),
		.apple_y    (apple_y)
	);

	frame_painter frame_painter_inst (
		.clk         (clk),
		.rst_n       (rst_n),
		.game_state  (game_state),
		.apple_x     (apple_x),
		.apple_y     (apple_y),
		.scan_x      (scan_x),
		.scan_y      (scan_y),
		.scan_colour (scan_colour),
		.plot        (plot),
		.draw_x      (draw_x),
		.draw_y      (draw_y),
		.colour      (colour),
		.paint_done  (paint_done)
	);

	collision_checker collision_checker_inst (
		.clk        (clk),
		.rst_n      (rst_n),
		.game_state (game_state),
		.head_x     (head_x),
		.head_y     (head_y),
		.scan_x     (scan_x),
		.scan_y     (scan_y),
		.scan_first (scan_first),
		.apple_x    (apple_x),
		.apple_y    (apple_y),
		.collision  (collision),
		.apple_hit  (apple_hit)
	);

endmodule

`default_nettype wire

// ==== verification/snake_model.svh ====
`ifndef SNAKE_MODEL_SVH
`define SNAKE_MODEL_SVH

// reference snake in full-length arrays so a grown tail is the last shifted cell
coord_x_t m_x [MAX_LEN];
coord_y_t m_y [MAX_LEN];
// palette index per segment where 0 is red
int m_ci [MAX_LEN];
int m_size;
dir_t m_dir;
coord_x_t m_ax;
coord_y_t m_ay;

// rainbow order red, yellow, green, cyan, blue, magenta
function automatic colour_t rainbow(int i);
	case (i)
		0: return 3'b100;
		1: return 3'b110;
		2: return 3'b010;
		3: return 3'b011;
		4: return 3'b001;
		default: return 3'b101;
	endcase
endfunction

// a 7-bit field lands in 0..99, then clears the wall
function automatic int fold_field(int v);
	return (v % APPLE_SPAN) + WALL_T;
endfunction

function automatic bit in_band(int x, int y);
	return x < WALL_T || x >= GRID_W - WALL_T || y < WALL_T || y >= GRID_H - WALL_T;
endfunction

task automatic load_start_snake();
	// head at the start cell with the body trailing right
	for (int i = 0; i < 5; i++) begin
		m_x[i] = coord_x_t'(30 + i);
		m_y[i] = 7'd20;
		m_ci[i] = i;
	end
	m_size = 5;
	m_dir = DIR_LEFT;
endtask

task automatic place_apple(input rand_t word);
	m_ax = coord_x_t'(fold_field(word[6:0]));
	m_ay = coord_y_t'(fold_field(word[13:7]));
endtask

// keys are left, right, down, up from the msb
task automatic step_snake(input logic [3:0] keys, output bit died, output bit ate);
	if (keys[3] && m_dir != DIR_RIGHT)
		m_dir = DIR_LEFT;
	else if (keys[2] && m_dir != DIR_LEFT)
		m_dir = DIR_RIGHT;
	else if (keys[1] && m_dir != DIR_UP)
		m_dir = DIR_DOWN;
	else if (keys[0] && m_dir != DIR_DOWN)
		m_dir = DIR_UP;
	for (int i = MAX_LEN - 1; i > 0; i--) begin
		m_x[i] = m_x[i-1];
		m_y[i] = m_y[i-1];
	end
	case (m_dir)
		DIR_LEFT: m_x[0] = m_x[0] - 1'b1;
		DIR_RIGHT: m_x[0] = m_x[0] + 1'b1;
		DIR_DOWN: m_y[0] = m_y[0] + 1'b1;
		default: m_y[0] = m_y[0] - 1'b1;
	endcase
	died = in_band(m_x[0], m_y[0]);
	// head against every body segment
	for (int i = 1; i < m_size; i++)
		if (m_x[i] == m_x[0] && m_y[i] == m_y[0])
			died = 1'b1;
	ate = !died && m_x[0] == m_ax && m_y[0] == m_ay;
	if (ate) begin
		for (int i = MAX_LEN - 1; i > 0; i--)
			m_ci[i] = m_ci[i-1];
		// new head steps back one palette entry
		m_ci[0] = (m_ci[1] + 5) % 6;
		if (m_size < MAX_LEN)
			m_size++;
	end
endtask

// next plot strobe as sampled on the falling edge
task automatic next_pixel(output coord_x_t x, output coord_y_t y, output colour_t c);
	int waited;
	waited = 0;
	x = '0;
	y = '0;
	c = '0;
	if (stalled)
		return;
	@(negedge clk);
	while (plot !== 1'b1 && waited < GAP_LIMIT) begin
		waited++;
		@(negedge clk);
	end
	assert (plot === 1'b1) else begin
		stalled = 1'b1;
		other_errs++;
		$display("pixel stream stopped, no plot strobe for %0d cycles", GAP_LIMIT);
	end
	x = draw_x;
	y = draw_y;
	c = colour;
endtask

task automatic compare_pixel(input string name, input int ex, input int ey, input colour_t ec);
	coord_x_t gx;
	coord_y_t gy;
	colour_t gc;
	next_pixel(gx, gy, gc);
	if (stalled)
		return;
	assert (gx === coord_x_t'(ex) && gy === coord_y_t'(ey) && gc === ec) else begin
		value_errs++;
		$display("ERR %s: expected (%0d,%0d) colour %b, got (%0d,%0d) colour %b",
			name, ex, ey, ec, gx, gy, gc);
	end
endtask

// whole frame of clear, wall band, apple and snake with the head first
task automatic check_frame(input string name);
	string n_clear;
	string n_wall;
	string n_apple;
	string n_snake;
	n_clear = {name, " clear"};
	n_wall = {name, " wall"};
	n_apple = {name, " apple"};
	n_snake = {name, " snake"};
	compare_pixel(n_clear, 0, 0, 3'b000);
	if (stalled)
		return;
	// the apple is already latched so the next word serves a later placement
	@(posedge clk);
	#5;
	rand_next = rand_t'($random(seed));
	random_in = rand_next;
	for (int y = 0; y < GRID_H; y++)
		for (int x = 0; x < GRID_W; x++)
			if ((x != 0 || y != 0) && !stalled)
				compare_pixel(n_clear, x, y, 3'b000);
	for (int y = 0; y < GRID_H; y++)
		for (int x = 0; x < GRID_W; x++)
			if (in_band(x, y) && !stalled)
				compare_pixel(n_wall, x, y, 3'b001);
	compare_pixel(n_apple, m_ax, m_ay, 3'b100);
	for (int i = 0; i < m_size; i++)
		compare_pixel(n_snake, m_x[i], m_y[i], rainbow(m_ci[i]));
	if (!stalled) begin
		assert (snake_size === seg_count_t'(m_size)) else begin
			value_errs++;
			$display("ERR %s size: expected %0d, got %0d", name, m_size, snake_size);
		end
	end
endtask

`endif

// ==== verification/snake_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module snake_tb import snake_geom_pkg::*, snake_game_pkg::*; ();

	localparam int MAX_LEN = 128;
	localparam int DELAY_TICKS = 20;
	// straight run onto the first apple, then random steering, then up into the wall
	localparam int MOVE_LIMIT = 60;
	localparam int RANDOM_MOVES = 12;
	localparam int GAP_LIMIT = 400;
	localparam int QUIET_CYCLES = 2000;
	// every planned move costs at most two sweeps plus the scans
	localparam real WATCHDOG_NS = (MOVE_LIMIT + 4) * (2.0 * 19200 + 300) * 100.0;

	logic clk;
	logic rst_n;
	logic mv_left;
	logic mv_right;
	logic mv_down;
	logic mv_up;
	rand_t random_in;
	logic plot;
	coord_x_t draw_x;
	coord_y_t draw_y;
	colour_t colour;
	seg_count_t snake_size;
	logic dead;

	int seed;
	int value_errs;
	int other_errs;
	int dead_pulses;
	bit stalled;
	rand_t rand_next;

	`include "snake_model.svh"

	snake_top #(
		.MAX_LEN(MAX_LEN),
		.DELAY_TICKS(DELAY_TICKS)
	) snake_top_inst (
		.clk        (clk),
		.rst_n      (rst_n),
		.mv_left    (mv_left),
		.mv_right   (mv_right),
		.mv_down    (mv_down),
		.mv_up      (mv_up),
		.random_in  (random_in),
		.plot       (plot),
		.draw_x     (draw_x),
		.draw_y     (draw_y),
		.colour     (colour),
		.snake_size (snake_size),
		.dead       (dead)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(negedge clk)
		if (dead === 1'b1)
			dead_pulses++;

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired before the test sequence finished");
		$display("errors: %0d value, %0d other", value_errs, other_errs + 1);
		$display("TEST FAILED");
		$finish;
	end

	task automatic drive_keys(input logic [3:0] keys);
		@(posedge clk);
		#5;
		{mv_left, mv_right, mv_down, mv_up} = keys;
	endtask

	// no pixel may appear for the given number of cycles
	task automatic ensure_no_plot(input string name, input int cycles);
		repeat (cycles) begin
			@(negedge clk);
			assert (plot === 1'b0) else begin
				value_errs++;
				$display("ERR %s: expected plot 0, got %b", name, plot);
			end
		end
	endtask

	task automatic start_game(input string name, input rand_t word);
		@(posedge clk);
		#5;
		random_in = word;
		drive_keys(4'b0001);
		ensure_no_plot({name, " press"}, 8);
		drive_keys(4'b0000);
		load_start_snake();
		place_apple(word);
	endtask

	// keys go up at the start of the delay and drop once the move has been taken
	task automatic steer(input logic [3:0] keys);
		drive_keys(keys);
		repeat (DELAY_TICKS) @(posedge clk);
		#5;
		{mv_left, mv_right, mv_down, mv_up} = 4'b0000;
	endtask

	function automatic logic [3:0] pick_keys(input int move);
		if (move < 4)
			return 4'b0000;
		if (move < 4 + RANDOM_MOVES)
			return 4'($random(seed));
		// left first when heading down, since up would be a reversal
		if (m_dir == DIR_DOWN)
			return 4'b1000;
		return 4'b0001;
	endfunction

	initial begin
		logic [3:0] keys;
		bit died;
		bit ate;
		int moves;
		seed = 80;
		value_errs = 0;
		other_errs = 0;
		dead_pulses = 0;
		stalled = 1'b0;
		rst_n = 1'b0;
		{mv_left, mv_right, mv_down, mv_up} = 4'b0000;
		random_in = '0;
		rand_next = '0;
		repeat (10) @(posedge clk);
		#5;
		rst_n = 1'b1;
		ensure_no_plot("idle", 20);
		assert (dead_pulses == 0) else begin
			value_errs++;
			$display("ERR idle dead: expected 0 dead pulses, got %0d", dead_pulses);
		end
		// apple four cells left of the start head at (26,20)
		start_game("start", {7'd18, 7'd24});
		died = 1'b0;
		moves = 0;
		while (!died && !stalled && moves < MOVE_LIMIT) begin
			check_frame($sformatf("frame %0d", moves));
			if (!stalled) begin
				keys = pick_keys(moves);
				steer(keys);
				step_snake(keys, died, ate);
				if (ate)
					place_apple(rand_next);
				moves++;
			end
		end
		assert (died || stalled) else begin
			other_errs++;
			$display("snake still alive after %0d moves", MOVE_LIMIT);
		end
		if (died && !stalled) begin
			ensure_no_plot("after death", QUIET_CYCLES);
			assert (dead_pulses == 1) else begin
				value_errs++;
				$display("ERR death: expected 1 dead pulse, got %0d", dead_pulses);
			end
			assert (snake_size === seg_count_t'(m_size)) else begin
				value_errs++;
				$display("ERR death size: expected %0d, got %0d", m_size, snake_size);
			end
			start_game("restart", rand_t'($random(seed)));
			check_frame("restart frame");
		end
		$display("errors: %0d value, %0d other", value_errs, other_errs);
		if (value_errs == 0 && other_errs == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+verification
design/snake_geom_pkg.sv
design/snake_game_pkg.sv
design/snake_control.sv
design/snake_body.sv
design/apple_placer.sv
design/frame_painter.sv
design/collision_checker.sv
design/snake_top.sv
verification/snake_tb.sv
